/* logic/core_pkg.sv */
package core_pkg;

  // instruction address, byte granular
  typedef logic [15:0] addr_t;

  // register index, r0 is hardwired and never creates a dependency
  typedef logic [4:0] reg_idx_t;

  // toy opcode set, enough to exercise every hazard path
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_ALU    = 3'd1,
    OP_LOAD   = 3'd2,  // waits on data memory in MEM
    OP_JUMP   = 3'd3,  // resolved in EX
    OP_MULDIV = 3'd4   // occupies EX for several cycles
  } op_t;

  // one control bit per stage register
  typedef logic [5:0] stage_vec_t;

  // stage bit positions in stall and flush vectors
  localparam int ST_PC  = 0;
  localparam int ST_IF  = 1;  // IF/ID register
  localparam int ST_ID  = 2;  // ID/EX register
  localparam int ST_EX  = 3;  // EX/MEM register
  localparam int ST_MEM = 4;  // MEM/WB register
  localparam int ST_WB  = 5;

  // fetch sequencing
  localparam addr_t PC_STEP  = 16'd4;
  localparam addr_t RESET_PC = 16'h0000;

  // mul/div occupancy of EX, in cycles
  localparam int MULDIV_CYCLES = 4;
  localparam int MULDIV_CNT_W  = $clog2(MULDIV_CYCLES);

  // remaining busy cycles of a mul/div
  typedef logic [MULDIV_CNT_W-1:0] md_cnt_t;

endpackage

/* logic/pc_gen.sv */
module pc_gen (
  input  logic            clk,
  input  logic            rst,
  input  logic            stall_i,        // hold current fetch address
  input  logic            jump_i,         // redirect from EX
  input  core_pkg::addr_t jump_target_i,
  output core_pkg::addr_t pc_o
);

  import core_pkg::*;

  // stall outranks the redirect, a held jump retries once EX moves again
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= RESET_PC;
    end else if (stall_i) begin
      pc_o <= pc_o;
    end else if (jump_i) begin
      pc_o <= jump_target_i;
    end else begin
      pc_o <= pc_o + PC_STEP;  // sequential fetch
    end
  end

endmodule

/* logic/fetch_stage.sv */
module fetch_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall_i,
  input  logic               flush_i,
  input  logic               fetch_ready_i,  // program memory answered this cycle
  input  core_pkg::addr_t    pc_i,
  // instruction fields from program memory
  input  core_pkg::op_t      op_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::addr_t    target_i,
  // IF/ID register
  output logic               valid_o,
  output core_pkg::addr_t    pc_o,
  output core_pkg::op_t      op_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::reg_idx_t rs1_o,
  output core_pkg::reg_idx_t rs2_o,
  output core_pkg::addr_t    target_o
);

  // valid bit, a flush leaves a bubble
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= fetch_ready_i;
    end
  end

  // instruction payload, only meaningful with valid_o
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_o     <= pc_i;
      op_o     <= op_i;
      rd_o     <= rd_i;
      rs1_o    <= rs1_i;
      rs2_o    <= rs2_i;
      target_o <= target_i;
    end
  end

endmodule

/* logic/decode_stage.sv */
module decode_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall_i,
  input  logic               flush_i,
  // IF/ID fields
  input  logic               valid_i,
  input  core_pkg::addr_t    pc_i,
  input  core_pkg::op_t      op_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::addr_t    target_i,
  // ID/EX register, i.e. the instruction now in EX
  output logic               valid_o,
  output core_pkg::addr_t    pc_o,
  output core_pkg::op_t      op_o,
  output core_pkg::reg_idx_t rd_o,
  output core_pkg::addr_t    target_o,
  output logic               load_use_o  // ID consumer of the load in EX
);

  import core_pkg::*;

  logic ex_is_load;
  logic src_match;

  assign ex_is_load = valid_o && (op_o == OP_LOAD);

  // r0 never forms a dependency
  assign src_match = (rd_o != '0) && ((rs1_i == rd_o) || (rs2_i == rd_o));

  // loaded data is not ready before MEM, one bubble is needed
  assign load_use_o = valid_i && ex_is_load && src_match;

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_o     <= pc_i;
      op_o     <= op_i;
      rd_o     <= rd_i;
      target_o <= target_i;
    end
  end

endmodule

/* logic/execute_stage.sv */
module execute_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall_i,
  input  logic               flush_i,
  // ID/EX fields, the instruction being executed
  input  logic               valid_i,
  input  core_pkg::addr_t    pc_i,
  input  core_pkg::op_t      op_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::addr_t    target_i,
  // EX/MEM register
  output logic               valid_o,
  output core_pkg::addr_t    pc_o,
  output core_pkg::op_t      op_o,
  output core_pkg::reg_idx_t rd_o,
  // hazard requests
  output logic               jump_o,
  output core_pkg::addr_t    jump_target_o,
  output logic               muldiv_busy_o
);

  import core_pkg::*;

  logic    md_op;   // mul/div sitting in EX
  logic    md_run;  // counter armed for that mul/div
  md_cnt_t md_cnt;

  // jumps resolve here, unconditionally taken
  assign jump_o        = valid_i && (op_i == OP_JUMP);
  assign jump_target_o = target_i;

  assign md_op = valid_i && (op_i == OP_MULDIV);

  // first EX cycle is busy before the counter is loaded
  assign muldiv_busy_o = md_op && (!md_run || (md_cnt != '0));

  // a load waiting in MEM freezes the count
  always_ff @(posedge clk) begin
    if (rst) begin
      md_run <= 1'b0;
      md_cnt <= '0;
    end else if (!md_op) begin
      md_run <= 1'b0;
    end else if (!stall_i) begin
      if (!md_run) begin
        md_run <= 1'b1;
        md_cnt <= md_cnt_t'(MULDIV_CYCLES - 2);
      end else if (md_cnt != '0) begin
        md_cnt <= md_cnt - 1'b1;
      end else begin
        md_run <= 1'b0;  // leaves EX this cycle
      end
    end
  end

  // busy mul/div is kept out of MEM by the flush
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      pc_o <= pc_i;
      op_o <= op_i;
      rd_o <= rd_i;
    end
  end

endmodule

/* logic/mem_stage.sv */
module mem_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush_i,
  input  logic               mem_ready_i,  // data memory level
  // EX/MEM fields
  input  logic               valid_i,
  input  core_pkg::addr_t    pc_i,
  input  core_pkg::op_t      op_i,
  input  core_pkg::reg_idx_t rd_i,
  output logic               mem_wait_o,
  // MEM/WB register, the retire stream
  output logic               wb_valid_o,
  output core_pkg::addr_t    wb_pc_o,
  output core_pkg::op_t      wb_op_o,
  output core_pkg::reg_idx_t wb_rd_o
);

  import core_pkg::*;

  // only loads touch data memory in this skeleton
  assign mem_wait_o = valid_i && (op_i == OP_LOAD) && !mem_ready_i;

  // never stalled, the waiting load is held upstream
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_pc_o <= pc_i;
    wb_op_o <= op_i;
    wb_rd_o <= rd_i;
  end

endmodule

/* logic/pipeline_control.sv */
module pipeline_control (
  input  logic                 rst,
  input  logic                 fetch_ready_i,
  input  logic                 mem_wait_i,     // load waiting in MEM
  input  logic                 jump_i,         // jump in EX
  input  logic                 muldiv_busy_i,  // mul/div still running in EX
  input  logic                 load_use_i,     // dependency from ID on a load in EX
  output core_pkg::stage_vec_t stall_o,
  output core_pkg::stage_vec_t flush_o
);

  import core_pkg::*;

  logic fetch_wait;

  assign fetch_wait = !fetch_ready_i;

  // later stage wins, checked oldest instruction first
  always_comb begin
    stall_o = '0;
    flush_o = '0;
    if (rst) begin
      flush_o[ST_WB:ST_PC] = '1;  // empty every stage
    end else if (mem_wait_i) begin
      stall_o[ST_EX:ST_PC] = '1;
      flush_o[ST_MEM]      = 1'b1;
    end else if (jump_i) begin
      // squash the two younger instructions, pc takes the target
      flush_o[ST_IF] = 1'b1;
      flush_o[ST_ID] = 1'b1;
    end else if (muldiv_busy_i) begin
      stall_o[ST_ID:ST_PC] = '1;
      flush_o[ST_EX]       = 1'b1;
    end else if (load_use_i) begin
      stall_o[ST_IF:ST_PC] = '1;
      flush_o[ST_ID]       = 1'b1;  // one bubble into EX
    end else if (fetch_wait) begin
      stall_o[ST_PC] = 1'b1;
      flush_o[ST_IF] = 1'b1;
    end
  end

endmodule

/* logic/pipe_top.sv */
module pipe_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_ready_i,
  input  logic               mem_ready_i,
  // program memory answer
  input  core_pkg::op_t      op_i,
  input  core_pkg::reg_idx_t rd_i,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  input  core_pkg::addr_t    target_i,
  output core_pkg::addr_t    fetch_pc_o,
  // retire stream
  output logic               wb_valid_o,
  output core_pkg::addr_t    wb_pc_o,
  output core_pkg::op_t      wb_op_o,
  output core_pkg::reg_idx_t wb_rd_o
);

  import core_pkg::*;

  stage_vec_t stall;
  stage_vec_t flush;

  // IF/ID
  logic     if_valid;
  addr_t    if_pc;
  op_t      if_op;
  reg_idx_t if_rd;
  reg_idx_t if_rs1;
  reg_idx_t if_rs2;
  addr_t    if_target;

  // ID/EX
  logic     id_valid;
  addr_t    id_pc;
  op_t      id_op;
  reg_idx_t id_rd;
  addr_t    id_target;

  // EX/MEM
  logic     ex_valid;
  addr_t    ex_pc;
  op_t      ex_op;
  reg_idx_t ex_rd;

  // hazard requests
  logic  load_use;
  logic  jump_ex;
  addr_t jump_target;
  logic  muldiv_busy;
  logic  mem_wait;

  pc_gen i_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall[ST_PC]),
    .jump_i        (jump_ex),
    .jump_target_i (jump_target),
    .pc_o          (fetch_pc_o)
  );

  fetch_stage i_fetch (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall[ST_IF]),
    .flush_i       (flush[ST_IF]),
    .fetch_ready_i (fetch_ready_i),
    .pc_i          (fetch_pc_o),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .target_i      (target_i),
    .valid_o       (if_valid),
    .pc_o          (if_pc),
    .op_o          (if_op),
    .rd_o          (if_rd),
    .rs1_o         (if_rs1),
    .rs2_o         (if_rs2),
    .target_o      (if_target)
  );

  decode_stage i_decode (
    .clk        (clk),
    .rst        (rst),
    .stall_i    (stall[ST_ID]),
    .flush_i    (flush[ST_ID]),
    .valid_i    (if_valid),
    .pc_i       (if_pc),
    .op_i       (if_op),
    .rd_i       (if_rd),
    .rs1_i      (if_rs1),
    .rs2_i      (if_rs2),
    .target_i   (if_target),
    .valid_o    (id_valid),
    .pc_o       (id_pc),
    .op_o       (id_op),
    .rd_o       (id_rd),
    .target_o   (id_target),
    .load_use_o (load_use)
  );

  execute_stage i_execute (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall[ST_EX]),
    .flush_i       (flush[ST_EX]),
    .valid_i       (id_valid),
    .pc_i          (id_pc),
    .op_i          (id_op),
    .rd_i          (id_rd),
    .target_i      (id_target),
    .valid_o       (ex_valid),
    .pc_o          (ex_pc),
    .op_o          (ex_op),
    .rd_o          (ex_rd),
    .jump_o        (jump_ex),
    .jump_target_o (jump_target),
    .muldiv_busy_o (muldiv_busy)
  );

  mem_stage i_mem (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush[ST_MEM]),
    .mem_ready_i (mem_ready_i),
    .valid_i     (ex_valid),
    .pc_i        (ex_pc),
    .op_i        (ex_op),
    .rd_i        (ex_rd),
    .mem_wait_o  (mem_wait),
    .wb_valid_o  (wb_valid_o),
    .wb_pc_o     (wb_pc_o),
    .wb_op_o     (wb_op_o),
    .wb_rd_o     (wb_rd_o)
  );

  pipeline_control i_control (
    .rst           (rst),
    .fetch_ready_i (fetch_ready_i),
    .mem_wait_i    (mem_wait),
    .jump_i        (jump_ex),
    .muldiv_busy_i (muldiv_busy),
    .load_use_i    (load_use),
    .stall_o       (stall),
    .flush_o       (flush)
  );

endmodule

/* bench/pipe_assertions.sv */
module pipe_assertions (
  input  logic               clk,
  input  logic               rst,
  input  logic               wb_valid_i,
  input  core_pkg::addr_t    wb_pc_i,
  input  core_pkg::op_t      wb_op_i,
  input  core_pkg::addr_t    fetch_pc_i,
  input  logic               mem_wait_i,     // load held in MEM
  input  logic               load_use_i,     // dependency on the load in EX
  input  core_pkg::addr_t    id_pc_i,        // pc of the instruction in EX
  input  logic               jump_i,
  input  core_pkg::addr_t    jump_target_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  int       fail_cnt = 0;
  addr_t    exp_pc;     // next pc the retire stream must show
  addr_t    jump_tgt;   // target of the last resolved jump
  logic     dep_armed;  // a load with a waiting consumer
  addr_t    dep_pc;
  logic [7:0] idle_cnt;  // cycles since the last retire

  // shadow of the retire stream
  always_ff @(posedge clk) begin
    if (rst) begin
      exp_pc    <= RESET_PC;
      jump_tgt  <= RESET_PC;
      dep_armed <= 1'b0;
      dep_pc    <= RESET_PC;
      idle_cnt  <= '0;
    end else begin
      if (jump_i) begin
        jump_tgt <= jump_target_i;
      end
      if (load_use_i) begin
        dep_armed <= 1'b1;
        dep_pc    <= id_pc_i;
      end else if (wb_valid_i && wb_op_i == OP_LOAD && wb_pc_i == dep_pc) begin
        dep_armed <= 1'b0;
      end
      if (wb_valid_i) begin
        exp_pc   <= (wb_op_i == OP_JUMP) ? jump_tgt : wb_pc_i + PC_STEP;
        idle_cnt <= '0;
      end else if (idle_cnt != 8'hff) begin
        idle_cnt <= idle_cnt + 8'd1;  // saturates
      end
    end
  end

  a_reset_state: assert property (@(posedge clk)
    rst |=> (!wb_valid_i && fetch_pc_i == RESET_PC))
    else begin
      $error("pipeline not empty or fetch pc wrong after reset");
      fail_cnt++;
    end

  // sequential or jump target, covers skips, repeats and squashed slots
  a_pc_order: assert property (@(posedge clk) disable iff (rst)
    wb_valid_i |-> (wb_pc_i == exp_pc))
    else begin
      $error("ERR wb_pc_o %h, expected %h", wb_pc_i, exp_pc);
      fail_cnt++;
    end

  a_load_bubble: assert property (@(posedge clk) disable iff (rst)
    (wb_valid_i && wb_op_i == OP_LOAD && dep_armed && wb_pc_i == dep_pc) |=> !wb_valid_i)
    else begin
      $error("dependent instruction retired right after its load");
      fail_cnt++;
    end

  // busy cycles in EX open a gap ahead of the mul/div
  a_muldiv_gap: assert property (@(posedge clk) disable iff (rst)
    (wb_valid_i && wb_op_i == OP_MULDIV) |-> (idle_cnt >= 8'(MULDIV_CYCLES - 1)))
    else begin
      $error("mul/div retired after only %0d idle cycles", idle_cnt);
      fail_cnt++;
    end

  a_mem_wait_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wait_i |=> !wb_valid_i)
    else begin
      $error("instruction retired while a load waited in MEM");
      fail_cnt++;
    end

endmodule

bind pipe_top pipe_assertions i_asrt (
  .clk           (clk),
  .rst           (rst),
  .wb_valid_i    (wb_valid_o),
  .wb_pc_i       (wb_pc_o),
  .wb_op_i       (wb_op_o),
  .fetch_pc_i    (fetch_pc_o),
  .mem_wait_i    (mem_wait),
  .load_use_i    (load_use),
  .id_pc_i       (id_pc),
  .jump_i        (jump_ex),
  .jump_target_i (jump_target)
);

/* bench/pipe_tb.sv */
module pipe_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int N_RETIRE   = 400;
  localparam int MAX_CYCLES = 20000;

  logic     clk;
  logic     rst;
  logic     fetch_ready;
  logic     mem_ready;
  op_t      op;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  addr_t    target;
  addr_t    fetch_pc;
  logic     wb_valid;
  addr_t    wb_pc;
  op_t      wb_op;
  reg_idx_t wb_rd;

  // program table, indexed by pc[7:2]
  op_t      tab_op[64];
  reg_idx_t tab_rd[64];
  reg_idx_t tab_rs1[64];
  reg_idx_t tab_rs2[64];
  addr_t    tab_target[64];

  logic [31:0] lfsr_state;
  int          retire_cnt;
  int          tb_errors;
  int          cycles;

  pipe_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .fetch_ready_i (fetch_ready),
    .mem_ready_i   (mem_ready),
    .op_i          (op),
    .rd_i          (rd),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .target_i      (target),
    .fetch_pc_o    (fetch_pc),
    .wb_valid_o    (wb_valid),
    .wb_pc_o       (wb_pc),
    .wb_op_o       (wb_op),
    .wb_rd_o       (wb_rd)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic op_t pick_op(input logic [7:0] v);
    case (v[2:0])
      3'd0:    return OP_NOP;
      3'd3:    return OP_LOAD;
      3'd4:    return OP_LOAD;   // loads twice as likely, more load-use cases
      3'd5:    return OP_JUMP;
      3'd6:    return OP_MULDIV;
      default: return OP_ALU;
    endcase
  endfunction

  always #4 clk = ~clk;

  // program memory answer and ready levels, driven off the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      fetch_ready <= (take_bits(2) != 8'd0);  // about 3 in 4 ready
      mem_ready   <= (take_bits(2) != 8'd0);
    end
    op     <= tab_op[fetch_pc[7:2]];
    rd     <= tab_rd[fetch_pc[7:2]];
    rs1    <= tab_rs1[fetch_pc[7:2]];
    rs2    <= tab_rs2[fetch_pc[7:2]];
    target <= tab_target[fetch_pc[7:2]];
  end

  // retired fields must match the program entry at that pc
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      retire_cnt++;
      if (wb_op != tab_op[wb_pc[7:2]]) begin
        $display("ERR wb_op_o %h, expected %h at pc %h", wb_op, tab_op[wb_pc[7:2]], wb_pc);
        tb_errors++;
      end
      if (wb_rd != tab_rd[wb_pc[7:2]]) begin
        $display("ERR wb_rd_o %h, expected %h at pc %h", wb_rd, tab_rd[wb_pc[7:2]], wb_pc);
        tb_errors++;
      end
    end
  end

  initial begin
    clk        = 1'b0;
    lfsr_state = 32'h8679;
    // few registers so dependencies are frequent
    for (int i = 0; i < 64; i++) begin
      tab_op[i]     = pick_op(take_bits(3));
      tab_rd[i]     = reg_idx_t'(take_bits(2));
      tab_rs1[i]    = reg_idx_t'(take_bits(2));
      tab_rs2[i]    = reg_idx_t'(take_bits(2));
      tab_target[i] = addr_t'(take_bits(6)) << 2;
    end
    rst         = 1'b1;
    fetch_ready = 1'b0;
    mem_ready   = 1'b0;
    op          = tab_op[0];
    rd          = tab_rd[0];
    rs1         = tab_rs1[0];
    rs2         = tab_rs2[0];
    target      = tab_target[0];
    retire_cnt  = 0;
    tb_errors   = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (retire_cnt < N_RETIRE && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles waiting for retirements", cycles);
      tb_errors++;
    end
    if (retire_cnt < N_RETIRE) begin
      $display("retire count short, %0d of %0d instructions retired", retire_cnt, N_RETIRE);
      tb_errors++;
    end
    $display("errors: bench %0d, assertions %0d, retired %0d",
             tb_errors, i_dut.i_asrt.fail_cnt, retire_cnt);
    if (tb_errors == 0 && i_dut.i_asrt.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/core_pkg.sv
logic/pc_gen.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/pipeline_control.sv
logic/pipe_top.sv
bench/pipe_assertions.sv
bench/pipe_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pipe_tb -f sim.f -o pipe_sim

out=$(./obj_dir/pipe_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
else
  exit 1
fi
